// File: hdl/memStage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////////////////////////////

// Data memory size in words, mapped from address 0
`define MEM_WORDS 1024

// Memory-mapped I/O window
`define IO_BASE 32'h0000_7F00
`define IO_BYTES 32'd16

////////////////////////////////////////////////////////////////////////////
// Program counter vectors
////////////////////////////////////////////////////////////////////////////

`define RESET_PC 32'h0000_3000
`define HANDLER_PC 32'h0000_4180

// Address error exception codes
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5

`endif

// File: hdl/memStagePkg.sv
`default_nettype none

package memStagePkg;

	// Data and address word
	typedef logic [31:0] word_t;

	// Register file index
	typedef logic [4:0] regAddr_t;

	// Hazard timing count (Tuse / Tnew)
	typedef logic [2:0] timing_t;

	typedef logic [4:0] excCode_t;

	// One enable per byte lane
	typedef logic [3:0] byteEn_t;

	// Operations that matter to the memory stage
	typedef enum logic [3:0]
	{
		opNone,
		opLw,
		opLh,
		opLhu,
		opLb,
		opLbu,
		opSw,
		opSh,
		opSb,
		opMfc0,
		opMtc0,
		opEret
	} memOp_t;

	// Load extension done later in write-back
	typedef enum logic [2:0]
	{
		extNone,
		extWord,
		extHalfSigned,
		extHalfZero,
		extByteSigned,
		extByteZero
	} extOp_t;

	typedef enum logic
	{
		fromExecute,
		fromWriteBack
	} bypassSel_t;

endpackage

`default_nettype wire

// File: hdl/byteEnableGen.sv
`timescale 1ns/1ps
`default_nettype none

module byteEnableGen
(
	input  wire memStagePkg::memOp_t memOp,
	input  wire [1:0]                addrLow,
	output memStagePkg::byteEn_t     byteEn
);

	always_comb
	begin
		case (memOp)
			memStagePkg::opLw, memStagePkg::opSw:
			begin
				byteEn = 4'b1111;
			end
			memStagePkg::opLh, memStagePkg::opLhu, memStagePkg::opSh:
			begin
				// Upper or lower half by address bit 1
				if (addrLow[1])
				begin
					byteEn = 4'b1100;
				end
				else
				begin
					byteEn = 4'b0011;
				end
			end
			memStagePkg::opLb, memStagePkg::opLbu, memStagePkg::opSb:
			begin
				case (addrLow)
					2'd0: byteEn = 4'b0001;
					2'd1: byteEn = 4'b0010;
					2'd2: byteEn = 4'b0100;
					default: byteEn = 4'b1000;
				endcase
			end
			default:
			begin
				byteEn = 4'b0000;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_settings.svh"

module dataMemory
(
	input  wire                        clk,
	input  wire                        arstN,
	input  wire memStagePkg::word_t    addr,
	input  wire memStagePkg::word_t    wData,
	input  wire                        wrEn,
	input  wire memStagePkg::byteEn_t  byteEn,
	output memStagePkg::word_t         rData
);

	localparam int IndexBits = $clog2(`MEM_WORDS);

	memStagePkg::word_t mem [0:`MEM_WORDS-1];
	logic [IndexBits-1:0] wordIndex;

	// Byte address to word index
	assign wordIndex = addr[IndexBits+1:2];

	// Asynchronous read
	assign rData = mem[wordIndex];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < `MEM_WORDS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (wrEn)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				if (byteEn[lane])
				begin
					mem[wordIndex][lane*8 +: 8] <= wData[lane*8 +: 8];
				end
			end
		end
	end

	// A store must select at least one lane
	assert property (@(posedge clk) disable iff (!arstN) wrEn |-> (byteEn != 4'b0000))
		else $error("dataMemory write with no byte lanes enabled");

endmodule

`default_nettype wire

// File: hdl/memAddressDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_settings.svh"

module memAddressDecode
(
	input  wire memStagePkg::memOp_t    memOp,
	input  wire memStagePkg::word_t     addr,
	input  wire                         exFault,
	input  wire memStagePkg::excCode_t  exExcCode,
	output logic                        fault,
	output memStagePkg::excCode_t       excCode,
	output logic                        isIo,
	output logic                        isDm
);

	localparam memStagePkg::word_t DmBytes = `MEM_WORDS * 4;
	localparam memStagePkg::word_t IoEnd = `IO_BASE + `IO_BYTES;

	logic isLoad;
	logic isStore;
	logic isWordOp;
	logic isHalfOp;
	logic misaligned;
	logic inDm;
	logic inIo;
	logic localFault;

	assign isLoad = memOp inside {memStagePkg::opLw, memStagePkg::opLh, memStagePkg::opLhu,
		memStagePkg::opLb, memStagePkg::opLbu};
	assign isStore = memOp inside {memStagePkg::opSw, memStagePkg::opSh, memStagePkg::opSb};
	assign isWordOp = (memOp == memStagePkg::opLw) || (memOp == memStagePkg::opSw);
	assign isHalfOp = memOp inside {memStagePkg::opLh, memStagePkg::opLhu, memStagePkg::opSh};

	// Range checks
	assign inDm = (addr < DmBytes);
	assign inIo = (addr >= `IO_BASE) && (addr < IoEnd);

	assign misaligned = (isWordOp && (addr[1:0] != 2'b00)) || (isHalfOp && addr[0]);

	// Only word accesses are allowed in the I/O window
	assign localFault = (isLoad || isStore) &&
		(misaligned || (inIo && !isWordOp) || (!inDm && !inIo));

	assign fault = exFault || localFault;

	// An execute-stage fault keeps its own code
	assign excCode = exFault ? exExcCode :
		localFault ? (isStore ? `EXC_ADES : `EXC_ADEL) : 5'd0;

	assign isIo = (isLoad || isStore) && inIo;
	assign isDm = (isLoad || isStore) && inDm;

endmodule

`default_nettype wire

// File: hdl/ioRegisterBank.sv
`timescale 1ns/1ps
`default_nettype none

module ioRegisterBank
(
	input  wire                      clk,
	input  wire                      arstN,
	input  wire                      wrEn,
	input  wire [1:0]                wordIndex,
	input  wire memStagePkg::word_t  wData,
	output memStagePkg::word_t       rData
);

	memStagePkg::word_t rwRegs [0:2];
	memStagePkg::word_t writeCount;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 3; i++)
			begin
				rwRegs[i] <= '0;
			end
			writeCount <= '0;
		end
		else if (wrEn)
		begin
			// Index 3 only bumps the counter
			if (wordIndex != 2'd3)
			begin
				rwRegs[wordIndex] <= wData;
			end
			writeCount <= writeCount + 32'd1;
		end
	end

	assign rData = (wordIndex == 2'd3) ? writeCount : rwRegs[wordIndex];

	assert property (@(posedge clk) disable iff (!arstN) !$isunknown(wrEn))
		else $error("ioRegisterBank wrEn is unknown");

endmodule

`default_nettype wire

// File: hdl/memStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_settings.svh"

module memStage
(
	input  wire                           clk,
	input  wire                           arstN,
	input  wire memStagePkg::memOp_t      memOp,
	input  wire memStagePkg::word_t       aluOut,
	input  wire memStagePkg::word_t       storeData,
	input  wire memStagePkg::word_t       pc,
	input  wire memStagePkg::regAddr_t    rsAddr,
	input  wire memStagePkg::regAddr_t    rtAddr,
	input  wire memStagePkg::regAddr_t    regWriteAddr,
	input  wire memStagePkg::timing_t     tuseRs,
	input  wire memStagePkg::timing_t     tuseRt,
	input  wire memStagePkg::timing_t     tnew,
	input  wire                           exFault,
	input  wire memStagePkg::excCode_t    exExcCode,
	input  wire memStagePkg::regAddr_t    cp0Reg,
	input  wire                           isBranchJump,
	input  wire memStagePkg::word_t       wbBypass,
	input  wire memStagePkg::bypassSel_t  bypassSel,
	input  wire memStagePkg::word_t       cp0RData,
	input  wire                           excTaken,
	input  wire memStagePkg::word_t       ioRData,
	output logic                          ioWrEn,
	output logic [1:0]                    ioAddr,
	output memStagePkg::word_t            ioWData,
	output memStagePkg::regAddr_t         hzRsAddr,
	output memStagePkg::regAddr_t         hzRtAddr,
	output memStagePkg::regAddr_t         hzRegWriteAddr,
	output memStagePkg::timing_t          hzTuseRs,
	output memStagePkg::timing_t          hzTuseRt,
	output memStagePkg::timing_t          hzTnew,
	output logic                          fault,
	output memStagePkg::excCode_t         excCode,
	output memStagePkg::word_t            cp0Addr,
	output memStagePkg::word_t            cp0WData,
	output logic                          eretEn,
	output logic                          bdFlag,
	output memStagePkg::word_t            wbPc,
	output memStagePkg::word_t            wbAluOut,
	output memStagePkg::regAddr_t         wbRegWriteAddr,
	output memStagePkg::timing_t          wbTuseRs,
	output memStagePkg::timing_t          wbTuseRt,
	output memStagePkg::timing_t          wbTnew,
	output memStagePkg::memOp_t           wbMemOp,
	output memStagePkg::word_t            wbReadData,
	output memStagePkg::extOp_t           wbExtOp,
	output logic                          wbLoad
);

	memStagePkg::word_t selStoreData;
	memStagePkg::word_t dmWData;
	memStagePkg::word_t dmRData;
	memStagePkg::word_t readData;
	memStagePkg::word_t lastBranchPc;
	memStagePkg::byteEn_t byteEn;
	memStagePkg::extOp_t extOp;
	logic isStore;
	logic isLoad;
	logic isIo;
	logic isDm;
	logic dmWrEn;
	logic flush;

	// Decrement toward zero and stay there
	function automatic memStagePkg::timing_t countDown(input memStagePkg::timing_t t);
		return (t != 3'd0) ? t - 3'd1 : 3'd0;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Store data and memory access
	////////////////////////////////////////////////////////////////////////////

	assign selStoreData = (bypassSel == memStagePkg::fromWriteBack) ? wbBypass : storeData;

	assign isStore = memOp inside {memStagePkg::opSw, memStagePkg::opSh, memStagePkg::opSb};
	assign isLoad = memOp inside {memStagePkg::opLw, memStagePkg::opLh, memStagePkg::opLhu,
		memStagePkg::opLb, memStagePkg::opLbu};

	// Replicate sub-word data so every lane sees it
	always_comb
	begin
		case (memOp)
			memStagePkg::opSh: dmWData = {2{selStoreData[15:0]}};
			memStagePkg::opSb: dmWData = {4{selStoreData[7:0]}};
			default: dmWData = selStoreData;
		endcase
	end

	memAddressDecode memAddressDecode_inst
	(
		.memOp(memOp),
		.addr(aluOut),
		.exFault(exFault),
		.exExcCode(exExcCode),
		.fault(fault),
		.excCode(excCode),
		.isIo(isIo),
		.isDm(isDm)
	);

	byteEnableGen byteEnableGen_inst
	(
		.memOp(memOp),
		.addrLow(aluOut[1:0]),
		.byteEn(byteEn)
	);

	assign dmWrEn = isStore && isDm && !fault && !excTaken;

	dataMemory dataMemory_inst
	(
		.clk(clk),
		.arstN(arstN),
		.addr(aluOut),
		.wData(dmWData),
		.wrEn(dmWrEn),
		.byteEn(byteEn),
		.rData(dmRData)
	);

	// I/O side, word stores only
	assign ioWrEn = (memOp == memStagePkg::opSw) && isIo && !fault && !excTaken;
	assign ioAddr = aluOut[3:2];
	assign ioWData = selStoreData;

	////////////////////////////////////////////////////////////////////////////
	// Hazard and coprocessor 0 outputs
	////////////////////////////////////////////////////////////////////////////

	assign hzRsAddr = rsAddr;
	assign hzRtAddr = rtAddr;
	assign hzRegWriteAddr = regWriteAddr;
	assign hzTuseRs = countDown(tuseRs);
	assign hzTuseRt = countDown(tuseRt);
	assign hzTnew = countDown(tnew);

	assign cp0Addr = {27'd0, cp0Reg};
	assign cp0WData = aluOut;
	assign eretEn = (memOp == memStagePkg::opEret);

	// Delay slot follows the last branch or jump
	assign bdFlag = (pc == lastBranchPc + 32'd4);

	always_comb
	begin
		case (memOp)
			memStagePkg::opLw: extOp = memStagePkg::extWord;
			memStagePkg::opLh: extOp = memStagePkg::extHalfSigned;
			memStagePkg::opLhu: extOp = memStagePkg::extHalfZero;
			memStagePkg::opLb: extOp = memStagePkg::extByteSigned;
			memStagePkg::opLbu: extOp = memStagePkg::extByteZero;
			default: extOp = memStagePkg::extNone;
		endcase
	end

	assign readData = (memOp == memStagePkg::opMfc0) ? cp0RData :
		isIo ? ioRData : dmRData;

	////////////////////////////////////////////////////////////////////////////
	// Write-back register
	////////////////////////////////////////////////////////////////////////////

	assign flush = excTaken || eretEn;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wbPc <= `RESET_PC;
			wbRegWriteAddr <= '0;
			wbTuseRs <= 3'd7;
			wbTuseRt <= 3'd7;
			wbTnew <= 3'd0;
			wbMemOp <= memStagePkg::opNone;
			wbExtOp <= memStagePkg::extNone;
			wbLoad <= 1'b0;
			lastBranchPc <= 32'hFFFF_FFFF;
		end
		else if (flush)
		begin
			// eret returns to the saved pc
			wbPc <= eretEn ? cp0RData : `HANDLER_PC;
			wbRegWriteAddr <= '0;
			wbTuseRs <= 3'd7;
			wbTuseRt <= 3'd7;
			wbTnew <= 3'd0;
			wbMemOp <= memStagePkg::opNone;
			wbExtOp <= memStagePkg::extNone;
			wbLoad <= 1'b0;
		end
		else
		begin
			wbPc <= pc;
			wbRegWriteAddr <= regWriteAddr;
			wbTuseRs <= hzTuseRs;
			wbTuseRt <= hzTuseRt;
			wbTnew <= hzTnew;
			wbMemOp <= memOp;
			wbExtOp <= extOp;
			wbLoad <= isLoad;
			if (isBranchJump)
			begin
				lastBranchPc <= pc;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		wbAluOut <= (memOp == memStagePkg::opMfc0) ? cp0RData : aluOut;
		wbReadData <= readData;
	end

	// Stores land only at aligned in-range addresses with no execute fault
	assert property (@(posedge clk) disable iff (!arstN)
		dmWrEn |-> (!exFault && (aluOut < `MEM_WORDS * 4) &&
			!((memOp == memStagePkg::opSw) && (aluOut[1:0] != 2'b00)) &&
			!((memOp == memStagePkg::opSh) && aluOut[0])))
		else $error("memStage faulting store reached data memory");

	// eret writes nothing and leaves a bubble behind it
	assert property (@(posedge clk) disable iff (!arstN)
		eretEn |-> (!dmWrEn && !ioWrEn) ##1 (wbMemOp == memStagePkg::opNone))
		else $error("memStage eret overlapped a memory operation");

endmodule

`default_nettype wire

// File: hdl/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem
(
	input  wire                           clk,
	input  wire                           arstN,
	input  wire memStagePkg::memOp_t      memOp,
	input  wire memStagePkg::word_t       aluOut,
	input  wire memStagePkg::word_t       storeData,
	input  wire memStagePkg::word_t       pc,
	input  wire memStagePkg::regAddr_t    rsAddr,
	input  wire memStagePkg::regAddr_t    rtAddr,
	input  wire memStagePkg::regAddr_t    regWriteAddr,
	input  wire memStagePkg::timing_t     tuseRs,
	input  wire memStagePkg::timing_t     tuseRt,
	input  wire memStagePkg::timing_t     tnew,
	input  wire                           exFault,
	input  wire memStagePkg::excCode_t    exExcCode,
	input  wire memStagePkg::regAddr_t    cp0Reg,
	input  wire                           isBranchJump,
	input  wire memStagePkg::word_t       wbBypass,
	input  wire memStagePkg::bypassSel_t  bypassSel,
	input  wire memStagePkg::word_t       cp0RData,
	input  wire                           excTaken,
	output memStagePkg::regAddr_t         hzRsAddr,
	output memStagePkg::regAddr_t         hzRtAddr,
	output memStagePkg::regAddr_t         hzRegWriteAddr,
	output memStagePkg::timing_t          hzTuseRs,
	output memStagePkg::timing_t          hzTuseRt,
	output memStagePkg::timing_t          hzTnew,
	output logic                          fault,
	output memStagePkg::excCode_t         excCode,
	output memStagePkg::word_t            cp0Addr,
	output memStagePkg::word_t            cp0WData,
	output logic                          eretEn,
	output logic                          bdFlag,
	output memStagePkg::word_t            wbPc,
	output memStagePkg::word_t            wbAluOut,
	output memStagePkg::regAddr_t         wbRegWriteAddr,
	output memStagePkg::timing_t          wbTuseRs,
	output memStagePkg::timing_t          wbTuseRt,
	output memStagePkg::timing_t          wbTnew,
	output memStagePkg::memOp_t           wbMemOp,
	output memStagePkg::word_t            wbReadData,
	output memStagePkg::extOp_t           wbExtOp,
	output logic                          wbLoad
);

	// Stage to I/O bank
	memStagePkg::word_t ioRData;
	memStagePkg::word_t ioWData;
	logic ioWrEn;
	logic [1:0] ioAddr;

	memStage memStage_inst
	(
		.clk(clk),
		.arstN(arstN),
		.memOp(memOp),
		.aluOut(aluOut),
		.storeData(storeData),
		.pc(pc),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.regWriteAddr(regWriteAddr),
		.tuseRs(tuseRs),
		.tuseRt(tuseRt),
		.tnew(tnew),
		.exFault(exFault),
		.exExcCode(exExcCode),
		.cp0Reg(cp0Reg),
		.isBranchJump(isBranchJump),
		.wbBypass(wbBypass),
		.bypassSel(bypassSel),
		.cp0RData(cp0RData),
		.excTaken(excTaken),
		.ioRData(ioRData),
		.ioWrEn(ioWrEn),
		.ioAddr(ioAddr),
		.ioWData(ioWData),
		.hzRsAddr(hzRsAddr),
		.hzRtAddr(hzRtAddr),
		.hzRegWriteAddr(hzRegWriteAddr),
		.hzTuseRs(hzTuseRs),
		.hzTuseRt(hzTuseRt),
		.hzTnew(hzTnew),
		.fault(fault),
		.excCode(excCode),
		.cp0Addr(cp0Addr),
		.cp0WData(cp0WData),
		.eretEn(eretEn),
		.bdFlag(bdFlag),
		.wbPc(wbPc),
		.wbAluOut(wbAluOut),
		.wbRegWriteAddr(wbRegWriteAddr),
		.wbTuseRs(wbTuseRs),
		.wbTuseRt(wbTuseRt),
		.wbTnew(wbTnew),
		.wbMemOp(wbMemOp),
		.wbReadData(wbReadData),
		.wbExtOp(wbExtOp),
		.wbLoad(wbLoad)
	);

	ioRegisterBank ioRegisterBank_inst
	(
		.clk(clk),
		.arstN(arstN),
		.wrEn(ioWrEn),
		.wordIndex(ioAddr),
		.wData(ioWData),
		.rData(ioRData)
	);

endmodule

`default_nettype wire

// File: verification/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "memStage_settings.svh"

module memSubsystemTb;

	localparam int RandomRounds = 40;
	// Upper bound on the directed operations below
	localparam int DirectedOps = 80;
	localparam int TotalOps = RandomRounds * 6 + DirectedOps;
	localparam int WatchdogNs = (TotalOps + 40) * 10;
	localparam int IndexTop = $clog2(`MEM_WORDS) + 1;

	typedef struct
	{
		logic fault;
		logic [4:0] excCode;
		logic [2:0] hzTuseRs;
		logic [2:0] hzTuseRt;
		logic [2:0] hzTnew;
		logic [31:0] cp0Addr;
		logic [31:0] cp0WData;
		logic eretEn;
		logic bdFlag;
		logic flush;
		logic dmWrite;
		logic ioWrite;
		logic [31:0] storeValue;
		logic checkAlu;
		logic checkRead;
		logic [31:0] wbPc;
		logic [31:0] wbAluOut;
		logic [31:0] wbReadData;
		logic [4:0] wbRegWriteAddr;
		logic [2:0] wbTuseRs;
		logic [2:0] wbTuseRt;
		logic [2:0] wbTnew;
		memStagePkg::memOp_t wbMemOp;
		memStagePkg::extOp_t wbExtOp;
		logic wbLoad;
	} expect_t;

	logic clk;
	logic arstN;
	memStagePkg::memOp_t memOp;
	memStagePkg::word_t aluOut;
	memStagePkg::word_t storeData;
	memStagePkg::word_t pc;
	memStagePkg::regAddr_t rsAddr;
	memStagePkg::regAddr_t rtAddr;
	memStagePkg::regAddr_t regWriteAddr;
	memStagePkg::timing_t tuseRs;
	memStagePkg::timing_t tuseRt;
	memStagePkg::timing_t tnew;
	logic exFault;
	memStagePkg::excCode_t exExcCode;
	memStagePkg::regAddr_t cp0Reg;
	logic isBranchJump;
	memStagePkg::word_t wbBypass;
	memStagePkg::bypassSel_t bypassSel;
	memStagePkg::word_t cp0RData;
	logic excTaken;

	memStagePkg::regAddr_t hzRsAddr;
	memStagePkg::regAddr_t hzRtAddr;
	memStagePkg::regAddr_t hzRegWriteAddr;
	memStagePkg::timing_t hzTuseRs;
	memStagePkg::timing_t hzTuseRt;
	memStagePkg::timing_t hzTnew;
	logic fault;
	memStagePkg::excCode_t excCode;
	memStagePkg::word_t cp0Addr;
	memStagePkg::word_t cp0WData;
	logic eretEn;
	logic bdFlag;
	memStagePkg::word_t wbPc;
	memStagePkg::word_t wbAluOut;
	memStagePkg::regAddr_t wbRegWriteAddr;
	memStagePkg::timing_t wbTuseRs;
	memStagePkg::timing_t wbTuseRt;
	memStagePkg::timing_t wbTnew;
	memStagePkg::memOp_t wbMemOp;
	memStagePkg::word_t wbReadData;
	memStagePkg::extOp_t wbExtOp;
	logic wbLoad;

	// Reference state
	logic [31:0] shadowMem [0:`MEM_WORDS-1];
	logic [31:0] shadowIo [0:2];
	logic [31:0] ioCount;
	logic [31:0] lastBranch;

	integer seed = 32'h836e;
	logic [31:0] nextPc;
	int checkCount = 0;
	int combErrors = 0;
	int wbErrors = 0;

	memSubsystem memSubsystem_inst
	(
		.clk(clk),
		.arstN(arstN),
		.memOp(memOp),
		.aluOut(aluOut),
		.storeData(storeData),
		.pc(pc),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.regWriteAddr(regWriteAddr),
		.tuseRs(tuseRs),
		.tuseRt(tuseRt),
		.tnew(tnew),
		.exFault(exFault),
		.exExcCode(exExcCode),
		.cp0Reg(cp0Reg),
		.isBranchJump(isBranchJump),
		.wbBypass(wbBypass),
		.bypassSel(bypassSel),
		.cp0RData(cp0RData),
		.excTaken(excTaken),
		.hzRsAddr(hzRsAddr),
		.hzRtAddr(hzRtAddr),
		.hzRegWriteAddr(hzRegWriteAddr),
		.hzTuseRs(hzTuseRs),
		.hzTuseRt(hzTuseRt),
		.hzTnew(hzTnew),
		.fault(fault),
		.excCode(excCode),
		.cp0Addr(cp0Addr),
		.cp0WData(cp0WData),
		.eretEn(eretEn),
		.bdFlag(bdFlag),
		.wbPc(wbPc),
		.wbAluOut(wbAluOut),
		.wbRegWriteAddr(wbRegWriteAddr),
		.wbTuseRs(wbTuseRs),
		.wbTuseRt(wbTuseRt),
		.wbTnew(wbTnew),
		.wbMemOp(wbMemOp),
		.wbReadData(wbReadData),
		.wbExtOp(wbExtOp),
		.wbLoad(wbLoad)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		#(WatchdogNs);
		$display("Watchdog expired: the simulation did not reach its end in time");
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [2:0] decrementFloor(input logic [2:0] t);
		return (t == 3'd0) ? 3'd0 : t - 3'd1;
	endfunction

	// Write-back fields of a pipeline bubble
	function automatic expect_t withBubble(input expect_t e, input logic [31:0] bubblePc);
		e.wbPc = bubblePc;
		e.wbRegWriteAddr = 5'd0;
		e.wbTuseRs = 3'd7;
		e.wbTuseRt = 3'd7;
		e.wbTnew = 3'd0;
		e.wbMemOp = memStagePkg::opNone;
		e.wbExtOp = memStagePkg::extNone;
		e.wbLoad = 1'b0;
		return e;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic expect_t refModel();
		expect_t e;
		logic isLoad;
		logic isStore;
		logic isWord;
		logic isHalf;
		logic inDm;
		logic inIo;
		logic localFault;
		isLoad = (memOp == memStagePkg::opLw) || (memOp == memStagePkg::opLh) ||
			(memOp == memStagePkg::opLhu) || (memOp == memStagePkg::opLb) ||
			(memOp == memStagePkg::opLbu);
		isStore = (memOp == memStagePkg::opSw) || (memOp == memStagePkg::opSh) ||
			(memOp == memStagePkg::opSb);
		isWord = (memOp == memStagePkg::opLw) || (memOp == memStagePkg::opSw);
		isHalf = (memOp == memStagePkg::opLh) || (memOp == memStagePkg::opLhu) ||
			(memOp == memStagePkg::opSh);
		inDm = aluOut < 32'(`MEM_WORDS * 4);
		inIo = (aluOut >= `IO_BASE) && ((aluOut - `IO_BASE) < 32'd16);
		localFault = (isLoad || isStore) && ((isWord && (aluOut[1:0] != 2'd0)) ||
			(isHalf && aluOut[0]) || (inIo && !isWord) || (!inDm && !inIo));

		e.fault = exFault || localFault;
		e.excCode = exFault ? exExcCode : (isStore ? `EXC_ADES : `EXC_ADEL);
		e.hzTuseRs = decrementFloor(tuseRs);
		e.hzTuseRt = decrementFloor(tuseRt);
		e.hzTnew = decrementFloor(tnew);
		e.cp0Addr = {27'd0, cp0Reg};
		e.cp0WData = aluOut;
		e.eretEn = (memOp == memStagePkg::opEret);
		e.bdFlag = (pc == lastBranch + 32'd4);
		e.flush = excTaken || e.eretEn;

		e.storeValue = (bypassSel == memStagePkg::fromWriteBack) ? wbBypass : storeData;
		e.dmWrite = isStore && inDm && !e.fault && !excTaken;
		e.ioWrite = (memOp == memStagePkg::opSw) && inIo && !e.fault && !excTaken;

		// Read side
		e.checkAlu = 1'b1;
		e.wbAluOut = (memOp == memStagePkg::opMfc0) ? cp0RData : aluOut;
		e.checkRead = (isLoad && !e.fault) || (memOp == memStagePkg::opMfc0);
		if (memOp == memStagePkg::opMfc0)
		begin
			e.wbReadData = cp0RData;
		end
		else if (inIo)
		begin
			e.wbReadData = (aluOut[3:2] == 2'd3) ? ioCount : shadowIo[aluOut[3:2]];
		end
		else
		begin
			e.wbReadData = inDm ? shadowMem[aluOut[IndexTop:2]] : 32'd0;
		end

		if (e.flush)
		begin
			e = withBubble(e, excTaken ? `HANDLER_PC : cp0RData);
		end
		else
		begin
			e.wbPc = pc;
			e.wbRegWriteAddr = regWriteAddr;
			e.wbTuseRs = e.hzTuseRs;
			e.wbTuseRt = e.hzTuseRt;
			e.wbTnew = e.hzTnew;
			e.wbMemOp = memOp;
			e.wbLoad = isLoad;
			case (memOp)
				memStagePkg::opLw: e.wbExtOp = memStagePkg::extWord;
				memStagePkg::opLh: e.wbExtOp = memStagePkg::extHalfSigned;
				memStagePkg::opLhu: e.wbExtOp = memStagePkg::extHalfZero;
				memStagePkg::opLb: e.wbExtOp = memStagePkg::extByteSigned;
				memStagePkg::opLbu: e.wbExtOp = memStagePkg::extByteZero;
				default: e.wbExtOp = memStagePkg::extNone;
			endcase
		end
		return e;
	endfunction

	// State change that the coming edge makes
	task automatic applyEffects(input expect_t e);
		logic [IndexTop-2:0] index;
		index = aluOut[IndexTop:2];
		if (e.dmWrite)
		begin
			case (memOp)
				memStagePkg::opSw: shadowMem[index] = e.storeValue;
				memStagePkg::opSh: shadowMem[index][{aluOut[1], 4'd0} +: 16] = e.storeValue[15:0];
				default: shadowMem[index][{aluOut[1:0], 3'd0} +: 8] = e.storeValue[7:0];
			endcase
		end
		if (e.ioWrite)
		begin
			if (aluOut[3:2] != 2'd3)
			begin
				shadowIo[aluOut[3:2]] = e.storeValue;
			end
			ioCount = ioCount + 32'd1;
		end
		if (isBranchJump && !e.flush)
		begin
			lastBranch = pc;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected, input bit wbSide);
		checkCount++;
		assert (actual === expected)
		else
		begin
			if (wbSide)
			begin
				wbErrors++;
			end
			else
			begin
				combErrors++;
			end
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h (memOp %s)",
				$time, name, actual, expected, memOp.name());
		end
	endtask

	task automatic checkCombinational(input expect_t e);
		checkValue("fault", fault, e.fault, 1'b0);
		if (e.fault)
		begin
			checkValue("excCode", excCode, e.excCode, 1'b0);
		end
		checkValue("hzRsAddr", hzRsAddr, rsAddr, 1'b0);
		checkValue("hzRtAddr", hzRtAddr, rtAddr, 1'b0);
		checkValue("hzRegWriteAddr", hzRegWriteAddr, regWriteAddr, 1'b0);
		checkValue("hzTuseRs", hzTuseRs, e.hzTuseRs, 1'b0);
		checkValue("hzTuseRt", hzTuseRt, e.hzTuseRt, 1'b0);
		checkValue("hzTnew", hzTnew, e.hzTnew, 1'b0);
		checkValue("cp0Addr", cp0Addr, e.cp0Addr, 1'b0);
		checkValue("cp0WData", cp0WData, e.cp0WData, 1'b0);
		checkValue("eretEn", eretEn, e.eretEn, 1'b0);
		checkValue("bdFlag", bdFlag, e.bdFlag, 1'b0);
	endtask

	task automatic checkWriteBack(input expect_t e);
		checkValue("wbPc", wbPc, e.wbPc, 1'b1);
		checkValue("wbRegWriteAddr", wbRegWriteAddr, e.wbRegWriteAddr, 1'b1);
		checkValue("wbTuseRs", wbTuseRs, e.wbTuseRs, 1'b1);
		checkValue("wbTuseRt", wbTuseRt, e.wbTuseRt, 1'b1);
		checkValue("wbTnew", wbTnew, e.wbTnew, 1'b1);
		checkValue("wbMemOp", wbMemOp, e.wbMemOp, 1'b1);
		checkValue("wbExtOp", wbExtOp, e.wbExtOp, 1'b1);
		checkValue("wbLoad", wbLoad, e.wbLoad, 1'b1);
		if (e.checkAlu)
		begin
			checkValue("wbAluOut", wbAluOut, e.wbAluOut, 1'b1);
		end
		if (e.checkRead)
		begin
			checkValue("wbReadData", wbReadData, e.wbReadData, 1'b1);
		end
	endtask

	// Inputs are stable at the falling edge
	initial
	begin : compareProcess
		expect_t cur;
		expect_t prev;
		for (int i = 0; i < `MEM_WORDS; i++)
		begin
			shadowMem[i] = 32'd0;
		end
		for (int i = 0; i < 3; i++)
		begin
			shadowIo[i] = 32'd0;
		end
		ioCount = 32'd0;
		lastBranch = 32'hFFFF_FFFF;
		prev = withBubble(prev, `RESET_PC);
		prev.checkAlu = 1'b0;
		prev.checkRead = 1'b0;
		wait (arstN === 1'b1);
		forever
		begin
			@(negedge clk);
			cur = refModel();
			checkCombinational(cur);
			checkWriteBack(prev);
			applyEffects(cur);
			prev = cur;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	// New cycle with idle defaults and random side fields
	task automatic startCycle();
		@(posedge clk);
		#1;
		memOp = memStagePkg::opNone;
		aluOut = rand32();
		storeData = rand32();
		pc = nextPc;
		nextPc = nextPc + 32'd4;
		rsAddr = 5'(rand32());
		rtAddr = 5'(rand32());
		regWriteAddr = 5'(rand32());
		tuseRs = 3'(rand32());
		tuseRt = 3'(rand32());
		tnew = 3'(rand32());
		exFault = 1'b0;
		exExcCode = 5'd0;
		cp0Reg = 5'(rand32());
		isBranchJump = 1'b0;
		wbBypass = rand32();
		bypassSel = memStagePkg::fromExecute;
		cp0RData = rand32();
		excTaken = 1'b0;
	endtask

	task automatic access(input memStagePkg::memOp_t op, input logic [31:0] addr);
		startCycle();
		memOp = op;
		aluOut = addr;
	endtask

	task automatic runRandomMemory();
		logic [31:0] r;
		logic [31:0] base;
		logic [31:0] addr;
		memStagePkg::memOp_t op;
		repeat (RandomRounds)
		begin
			r = rand32();
			base = {20'd0, r[9:0], 2'b00};
			op = (r[11:10] == 2'd0) ? memStagePkg::opSw :
				(r[11:10] == 2'd1) ? memStagePkg::opSh : memStagePkg::opSb;
			addr = (op == memStagePkg::opSw) ? base :
				(op == memStagePkg::opSh) ? (base | {30'd0, r[12], 1'b0}) :
				(base | {30'd0, r[13:12]});
			access(op, addr);
			access(memStagePkg::opLw, base);
			access(memStagePkg::opLh, {addr[31:1], 1'b0});
			access(memStagePkg::opLhu, {addr[31:1], 1'b0});
			access(memStagePkg::opLb, addr);
			access(memStagePkg::opLbu, addr);
		end
	endtask

	task automatic runFaults();
		access(memStagePkg::opSw, 32'h100);
		storeData = 32'hA5A5_1234;
		access(memStagePkg::opSw, 32'h101);
		access(memStagePkg::opSh, 32'h103);
		access(memStagePkg::opSb, 32'h1000);
		// Execute-stage fault on an aligned store
		access(memStagePkg::opSw, 32'h100);
		exFault = 1'b1;
		exExcCode = 5'd12;
		access(memStagePkg::opLw, 32'h102);
		access(memStagePkg::opLh, 32'h105);
		access(memStagePkg::opLb, 32'hFFFF_FFF0);
		access(memStagePkg::opNone, 32'h0);
		exFault = 1'b1;
		exExcCode = 5'd10;
		access(memStagePkg::opLw, 32'h100);
		access(memStagePkg::opLhu, 32'h102);
	endtask

	task automatic runIo();
		for (int i = 0; i < 4; i++)
		begin
			access(memStagePkg::opSw, `IO_BASE + 32'(i * 4));
		end
		for (int i = 0; i < 4; i++)
		begin
			access(memStagePkg::opLw, `IO_BASE + 32'(i * 4));
		end
		// Sub-word and misaligned I/O accesses
		access(memStagePkg::opSh, `IO_BASE + 32'd4);
		access(memStagePkg::opSb, `IO_BASE + 32'd9);
		access(memStagePkg::opLbu, `IO_BASE);
		access(memStagePkg::opLw, `IO_BASE + 32'd2);
		access(memStagePkg::opSw, `IO_BASE + 32'd16);
		access(memStagePkg::opLw, `IO_BASE + 32'd12);
		access(memStagePkg::opLw, `IO_BASE + 32'd4);
	endtask

	task automatic runFlush();
		access(memStagePkg::opSw, 32'h200);
		storeData = 32'h1111_2222;
		access(memStagePkg::opSw, 32'h200);
		storeData = 32'h3333_4444;
		excTaken = 1'b1;
		access(memStagePkg::opLw, 32'h200);
		access(memStagePkg::opSw, `IO_BASE);
		excTaken = 1'b1;
		access(memStagePkg::opLw, `IO_BASE + 32'd12);
		access(memStagePkg::opEret, 32'h0);
		cp0RData = 32'h0000_3ABC;
		access(memStagePkg::opSb, 32'h201);
		excTaken = 1'b1;
		access(memStagePkg::opLw, 32'h200);
	endtask

	task automatic runBypass();
		access(memStagePkg::opSw, 32'h300);
		bypassSel = memStagePkg::fromWriteBack;
		access(memStagePkg::opLw, 32'h300);
		access(memStagePkg::opSb, 32'h302);
		bypassSel = memStagePkg::fromWriteBack;
		access(memStagePkg::opLw, 32'h300);
		access(memStagePkg::opSh, 32'h306);
		bypassSel = memStagePkg::fromWriteBack;
		access(memStagePkg::opLw, 32'h304);
		access(memStagePkg::opSw, `IO_BASE + 32'd8);
		bypassSel = memStagePkg::fromWriteBack;
		access(memStagePkg::opLw, `IO_BASE + 32'd8);
		// Timing fields at the floor and the top
		access(memStagePkg::opNone, 32'h0);
		tuseRs = 3'd0;
		tuseRt = 3'd1;
		tnew = 3'd7;
	endtask

	task automatic runBranchCp0();
		access(memStagePkg::opNone, 32'h0);
		isBranchJump = 1'b1;
		access(memStagePkg::opLw, 32'h300);
		access(memStagePkg::opNone, 32'h0);
		access(memStagePkg::opNone, 32'h0);
		isBranchJump = 1'b1;
		// Jump target is not the delay slot
		access(memStagePkg::opNone, 32'h0);
		pc = 32'h0000_5000;
		nextPc = 32'h0000_5004;
		access(memStagePkg::opNone, 32'h0);
		isBranchJump = 1'b1;
		access(memStagePkg::opMfc0, 32'h0);
		cp0Reg = 5'd14;
		access(memStagePkg::opMtc0, 32'hDEAD_BEEF);
		access(memStagePkg::opMfc0, 32'h0);
	endtask

	initial
	begin
		arstN = 1'b0;
		memOp = memStagePkg::opNone;
		aluOut = 32'd0;
		storeData = 32'd0;
		pc = 32'd0;
		rsAddr = 5'd0;
		rtAddr = 5'd0;
		regWriteAddr = 5'd0;
		tuseRs = 3'd0;
		tuseRt = 3'd0;
		tnew = 3'd0;
		exFault = 1'b0;
		exExcCode = 5'd0;
		cp0Reg = 5'd0;
		isBranchJump = 1'b0;
		wbBypass = 32'd0;
		bypassSel = memStagePkg::fromExecute;
		cp0RData = 32'd0;
		excTaken = 1'b0;
		nextPc = `RESET_PC;
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;

		runRandomMemory();
		runFaults();
		runIo();
		runFlush();
		runBypass();
		runBranchCp0();
		startCycle();
		startCycle();
		@(negedge clk);
		@(negedge clk);
		#1;

		$display("Summary: %0d checks, %0d combinational errors, %0d write-back errors",
			checkCount, combErrors, wbErrors);
		if ((combErrors + wbErrors) == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/memStagePkg.sv
hdl/byteEnableGen.sv
hdl/dataMemory.sv
hdl/memAddressDecode.sv
hdl/ioRegisterBank.sv
hdl/memStage.sv
hdl/memSubsystem.sv
verification/memSubsystemTb.sv

// File: run.sh
#!/bin/sh
# Build the memory-stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module memSubsystemTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VmemSubsystemTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0
